// File: rtl/mem_req_pkg.sv
`default_nettype none

package mem_req_pkg;

    // ############################################################
    // words and request kinds
    // ############################################################

    typedef logic [31:0] word_t;

    typedef enum logic [1:0] {
        REQ_FETCH = 2'd0,
        REQ_LOAD  = 2'd1,
        REQ_STORE = 2'd2
    } req_kind_t;

    // ############################################################
    // memory geometry and timing
    // ############################################################

    localparam int MEM_WORDS   = 256;
    localparam int MEM_IDX_W   = $clog2(MEM_WORDS);
    localparam int ADDR_LSB    = 2;                         // byte addresses are word aligned
    localparam int MEM_LATENCY = 2;                         // accept to response with hold low
    localparam int MEM_CREDITS = 2;                         // requests the memory can buffer
    localparam int CREDIT_W    = $clog2(MEM_CREDITS + 1);

    // ############################################################
    // fixed data words
    // ############################################################

    localparam word_t BUBBLE_WORD  = 32'h0000_0000;         // no-op shown to the cpu while frozen
    localparam word_t INVALID_WORD = 32'hBAD1_BAD1;         // read beyond the last word
    localparam word_t INIT_XOR     = 32'h5a5a_0000;         // word i starts as i xor this

endpackage

`default_nettype wire

// File: rtl/credit_queue.sv
`timescale 1ns/1ps
`default_nettype none

module credit_queue #(
    parameter type item_t = logic,
    parameter int  DEPTH  = 2
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  item_t push_item,
    input  logic  pop,
    output item_t pop_item,
    output logic  empty,
    output logic  full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    item_t            slots [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        else begin
            return ptr + 1'b1;
        end
    endfunction

    assign pop_item = slots[rd_ptr];                        // head is visible before the pop
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            slots[wr_ptr] <= push_item;
        end
    end

    // the credit scheme upstream has to keep the queue within its depth
    assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else $error("credit_queue push while full");

    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("credit_queue pop while empty");

endmodule

`default_nettype wire

// File: rtl/mem_request_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_request_unit
    import mem_req_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  word_t     pc,
    input  logic      branch_taken,
    input  word_t     branch_target,
    input  logic      mem_read,
    input  logic      mem_write,
    input  word_t     mem_address,
    input  word_t     store_data,
    input  logic      req_accept,
    input  logic      rsp_valid,
    input  req_kind_t rsp_kind,
    input  word_t     rsp_data,
    output logic      req_valid,
    output req_kind_t req_kind,
    output word_t     req_addr,
    output word_t     req_wdata,
    output word_t     instruction,
    output word_t     load_data,
    output logic      freeze
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DATA_REQ,
        ST_DATA_WAIT,
        ST_FETCH_REQ,
        ST_FETCH_WAIT
    } state_t;

    state_t state;
    state_t state_next;
    logic   data_done;                                      // data access of this step is finished
    logic   data_access;
    logic   fetch_done;
    word_t  fetch_addr;
    word_t  load_q;

    assign data_access = mem_read || mem_write;
    assign fetch_addr  = branch_taken ? branch_target : pc;
    assign fetch_done  = (state == ST_FETCH_WAIT) && rsp_valid && (rsp_kind == REQ_FETCH);

    // the step ends in the cycle the fetched word comes back
    assign freeze      = !fetch_done;
    assign instruction = fetch_done ? rsp_data : BUBBLE_WORD;
    assign load_data   = load_q;

    // ############################################################
    // step sequencing
    // ############################################################

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (data_access && !data_done) begin
                    state_next = ST_DATA_REQ;               // data goes ahead of the fetch
                end
                else begin
                    state_next = ST_FETCH_REQ;
                end
            end
            ST_DATA_REQ: begin
                if (req_accept) begin
                    state_next = ST_DATA_WAIT;
                end
            end
            ST_DATA_WAIT: begin
                if (rsp_valid) begin
                    state_next = ST_IDLE;                   // decide again, now with data_done set
                end
            end
            ST_FETCH_REQ: begin
                if (req_accept) begin
                    state_next = ST_FETCH_WAIT;
                end
            end
            ST_FETCH_WAIT: begin
                if (fetch_done) begin
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_comb begin
        req_valid = (state == ST_DATA_REQ) || (state == ST_FETCH_REQ);
        if (state == ST_DATA_REQ) begin
            req_kind = mem_write ? REQ_STORE : REQ_LOAD;
            req_addr = mem_address;
        end
        else begin
            req_kind = REQ_FETCH;
            req_addr = fetch_addr;
        end
        req_wdata = store_data;                             // only looked at for stores
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            data_done <= 1'b0;
            load_q    <= BUBBLE_WORD;
        end
        else begin
            state <= state_next;
            if ((state == ST_DATA_WAIT) && rsp_valid) begin
                data_done <= 1'b1;
                if (rsp_kind == REQ_LOAD) begin
                    load_q <= rsp_data;
                end
            end
            if (fetch_done) begin
                data_done <= 1'b0;                          // next step may access data again
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
        else $error("mem_read and mem_write both high");

    // the bus unit tags responses in order, so a fetch wait only ever sees a fetch
    assert property (@(posedge clk) disable iff (rst)
        ((state == ST_FETCH_WAIT) && rsp_valid) |-> (rsp_kind == REQ_FETCH))
        else $error("response kind does not match the pending fetch");

endmodule

`default_nettype wire

// File: rtl/mem_bus_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mem_bus_unit
    import mem_req_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req_valid,
    input  req_kind_t req_kind,
    input  word_t     req_addr,
    input  word_t     req_wdata,
    input  logic      credit_return,
    input  logic      mem_rsp_valid,
    input  word_t     mem_rsp_data,
    output logic      req_accept,
    output logic      rsp_valid,
    output req_kind_t rsp_kind,
    output word_t     rsp_data,
    output logic      mem_valid,
    output req_kind_t mem_kind,
    output word_t     mem_addr,
    output word_t     mem_wdata
);

    logic [CREDIT_W-1:0] credits;                           // free slots left in the memory
    logic                kind_empty;

    // ############################################################
    // request side
    // ############################################################

    assign req_accept = req_valid && (credits != '0);
    assign mem_valid  = req_accept;
    assign mem_kind   = req_kind;
    assign mem_addr   = req_addr;
    assign mem_wdata  = req_wdata;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CREDIT_W'(MEM_CREDITS);
        end
        else begin
            case ({req_accept, credit_return})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;        // spend and return cancel out
            endcase
        end
    end

    // ############################################################
    // response side
    // ############################################################

    // responses come back in order, so the oldest kind belongs to this response
    credit_queue #(
        .item_t (req_kind_t),
        .DEPTH  (MEM_CREDITS)
    ) u_kind_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (req_accept),
        .push_item (req_kind),
        .pop       (mem_rsp_valid),
        .pop_item  (rsp_kind),
        .empty     (kind_empty),
        .full      ()
    );

    assign rsp_valid = mem_rsp_valid;
    assign rsp_data  = mem_rsp_data;

    assert property (@(posedge clk) disable iff (rst) credits <= CREDIT_W'(MEM_CREDITS))
        else $error("credit count above the memory buffer size");

    assert property (@(posedge clk) disable iff (rst) mem_rsp_valid |-> !kind_empty)
        else $error("memory response with no request outstanding");

endmodule

`default_nettype wire

// File: rtl/wait_state_mem.sv
`timescale 1ns/1ps
`default_nettype none

module wait_state_mem
    import mem_req_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      hold,
    input  logic      mem_valid,
    input  req_kind_t mem_kind,
    input  word_t     mem_addr,
    input  word_t     mem_wdata,
    output logic      mem_rsp_valid,
    output word_t     mem_rsp_data,
    output logic      credit_return
);

    // the response queue adds the last cycle of latency
    localparam int STAGES = MEM_LATENCY - 1;

    word_t                mem_array [MEM_WORDS];
    logic [MEM_IDX_W-1:0] index;
    logic                 in_range;
    logic                 is_store;
    word_t                rsp_word;
    logic                 dly_valid [STAGES];
    word_t                dly_data  [STAGES];
    logic                 rsp_pop;
    logic                 rsp_empty;

    assign index    = mem_addr[ADDR_LSB +: MEM_IDX_W];
    assign in_range = (mem_addr[31:ADDR_LSB + MEM_IDX_W] == '0);
    assign is_store = (mem_kind == REQ_STORE);

    always_comb begin
        if (is_store) begin
            rsp_word = mem_wdata;                           // a store echoes what it wrote
        end
        else if (in_range) begin
            rsp_word = mem_array[index];
        end
        else begin
            rsp_word = INVALID_WORD;
        end
    end

    // ############################################################
    // storage
    // ############################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_array[i] <= word_t'(i) ^ INIT_XOR;
            end
        end
        else if (mem_valid && is_store && in_range) begin
            mem_array[index] <= mem_wdata;
        end
    end

    // ############################################################
    // latency line and response queue
    // ############################################################

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < STAGES; s++) begin
                dly_valid[s] <= 1'b0;
            end
        end
        else begin
            dly_valid[0] <= mem_valid;
            for (int s = 1; s < STAGES; s++) begin
                dly_valid[s] <= dly_valid[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        dly_data[0] <= rsp_word;
        for (int s = 1; s < STAGES; s++) begin
            dly_data[s] <= dly_data[s-1];
        end
    end

    credit_queue #(
        .item_t (word_t),
        .DEPTH  (MEM_CREDITS)
    ) u_rsp_queue (
        .clk       (clk),
        .rst       (rst),
        .push      (dly_valid[STAGES-1]),
        .push_item (dly_data[STAGES-1]),
        .pop       (rsp_pop),
        .pop_item  (mem_rsp_data),
        .empty     (rsp_empty),
        .full      ()
    );

    // hold parks responses in the queue and keeps their credits back
    assign rsp_pop       = !hold && !rsp_empty;
    assign mem_rsp_valid = rsp_pop;
    assign credit_return = rsp_pop;

endmodule

`default_nettype wire

// File: rtl/mem_subsys_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import mem_req_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  hold,
    input  word_t pc,
    input  logic  branch_taken,
    input  word_t branch_target,
    input  logic  mem_read,
    input  logic  mem_write,
    input  word_t mem_address,
    input  word_t store_data,
    output word_t instruction,
    output word_t load_data,
    output logic  freeze
);

    // request unit to bus unit
    logic      req_valid;
    req_kind_t req_kind;
    word_t     req_addr;
    word_t     req_wdata;
    logic      req_accept;
    logic      rsp_valid;
    req_kind_t rsp_kind;
    word_t     rsp_data;

    // bus unit to memory
    logic      mem_valid;
    req_kind_t mem_kind;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      credit_return;
    logic      mem_rsp_valid;
    word_t     mem_rsp_data;

    mem_request_unit u_request_unit (
        .clk           (clk),
        .rst           (rst),
        .pc            (pc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .store_data    (store_data),
        .req_accept    (req_accept),
        .rsp_valid     (rsp_valid),
        .rsp_kind      (rsp_kind),
        .rsp_data      (rsp_data),
        .req_valid     (req_valid),
        .req_kind      (req_kind),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .instruction   (instruction),
        .load_data     (load_data),
        .freeze        (freeze)
    );

    mem_bus_unit u_bus_unit (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_kind      (req_kind),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .credit_return (credit_return),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .req_accept    (req_accept),
        .rsp_valid     (rsp_valid),
        .rsp_kind      (rsp_kind),
        .rsp_data      (rsp_data),
        .mem_valid     (mem_valid),
        .mem_kind      (mem_kind),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata)
    );

    wait_state_mem u_mem (
        .clk           (clk),
        .rst           (rst),
        .hold          (hold),
        .mem_valid     (mem_valid),
        .mem_kind      (mem_kind),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .credit_return (credit_return)
    );

endmodule

`default_nettype wire

// File: verification/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam int PERIOD_NS    = 10;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;                                        // flops still see reset on this edge
    end

endmodule

`default_nettype wire

// File: verification/mem_subsys_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb
    import mem_req_pkg::*;
();

    localparam int NUM_DIRECTED  = 9;
    localparam int NUM_RANDOM    = 200;
    localparam int NUM_STEPS     = NUM_DIRECTED + NUM_RANDOM;
    localparam int STEP_TIMEOUT  = 200;
    localparam int RESET_TIMEOUT = 20;
    localparam int SAMPLE_NS     = 2;                       // outputs settle after the falling edge

    logic  clk;
    logic  rst;
    logic  hold;
    word_t pc;
    logic  branch_taken;
    word_t branch_target;
    logic  mem_read;
    logic  mem_write;
    word_t mem_address;
    word_t store_data;
    word_t instruction;
    word_t load_data;
    logic  freeze;

    word_t ref_mem [MEM_WORDS];
    word_t expected_load;
    word_t lfsr_state;
    int    checked_steps;

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    mem_subsys_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .hold          (hold),
        .pc            (pc),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .store_data    (store_data),
        .instruction   (instruction),
        .load_data     (load_data),
        .freeze        (freeze)
    );

    // ############################################################
    // reference model and checks
    // ############################################################

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic word_t ref_word(input word_t addr);
        if (addr >= word_t'(MEM_WORDS * 4)) begin
            return INVALID_WORD;                            // beyond the last word
        end
        else begin
            return ref_mem[addr[ADDR_LSB +: MEM_IDX_W]];
        end
    endfunction

    task automatic ref_store(input word_t addr, input word_t data);
        if (addr < word_t'(MEM_WORDS * 4)) begin
            ref_mem[addr[ADDR_LSB +: MEM_IDX_W]] = data;
        end
    endtask

    task automatic compare_instruction(input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH time %0t: instruction expected %h got %h",
                                $time, expected, actual));
        end
    endtask

    task automatic compare_load(input word_t actual, input word_t expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH time %0t: load_data expected %h got %h",
                                $time, expected, actual));
        end
    endtask

    task automatic sample_point();
        @(negedge clk);
        #(SAMPLE_NS);
    endtask

    task automatic check_step();
        word_t fetch_addr;
        if (hold) begin
            abort_run("freeze fell while the memory was on hold");
        end
        else begin
            if (mem_write) begin
                ref_store(mem_address, store_data);         // the store lands before the fetch
            end
            if (mem_read) begin
                expected_load = ref_word(mem_address);
            end
            fetch_addr = branch_taken ? branch_target : pc;
            compare_instruction(instruction, ref_word(fetch_addr));
            compare_load(load_data, expected_load);
            checked_steps++;
        end
    endtask

    initial begin : compare_results
        int waited;
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = word_t'(i) ^ INIT_XOR;
        end
        expected_load = BUBBLE_WORD;
        checked_steps = 0;
        waited        = 0;
        sample_point();
        while (rst) begin
            if (freeze !== 1'b1) begin
                abort_run("freeze was low during reset");
            end
            compare_instruction(instruction, BUBBLE_WORD);
            compare_load(load_data, BUBBLE_WORD);
            if (waited == RESET_TIMEOUT) begin
                abort_run("TIMEOUT: reset was never released");
            end
            else begin
                waited++;
                sample_point();
            end
        end
        forever begin
            waited = 0;
            while (freeze !== 1'b0) begin
                compare_instruction(instruction, BUBBLE_WORD);   // no-op while frozen
                if (waited == STEP_TIMEOUT) begin
                    abort_run($sformatf("TIMEOUT: freeze stayed high for %0d cycles in step %0d",
                                        STEP_TIMEOUT, checked_steps + 1));
                end
                else begin
                    waited++;
                    sample_point();
                end
            end
            check_step();
            sample_point();
        end
    end

    // ############################################################
    // stimulus
    // ############################################################

    function automatic word_t lfsr_next(input word_t state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic word_t random_bits(input int count);
        word_t value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic draw_hold();
        return (random_bits(2) == '0);                      // held about one cycle in four
    endfunction

    task automatic run_step(
        input word_t step_pc,
        input logic  taken,
        input word_t target,
        input logic  rd,
        input logic  wr,
        input word_t addr,
        input word_t wdata,
        input logic  random_hold
    );
        int target_count;
        int waited;
        pc            = step_pc;
        branch_taken  = taken;
        branch_target = target;
        mem_read      = rd;
        mem_write     = wr;
        mem_address   = addr;
        store_data    = wdata;
        hold          = random_hold ? draw_hold() : 1'b0;
        target_count  = checked_steps + 1;
        waited        = 0;
        @(negedge clk);
        while (checked_steps != target_count) begin
            if (waited == STEP_TIMEOUT) begin
                abort_run($sformatf("TIMEOUT: step %0d was not checked within %0d cycles",
                                    target_count, STEP_TIMEOUT));
            end
            else begin
                hold = random_hold ? draw_hold() : 1'b0;
                waited++;
                @(negedge clk);
            end
        end
    endtask

    initial begin : stimulus
        int    waited;
        word_t choice;
        word_t r_pc;
        logic  r_taken;
        word_t r_target;
        word_t r_addr;
        word_t r_data;
        hold          = 1'b0;
        pc            = '0;
        branch_taken  = 1'b0;
        branch_target = '0;
        mem_read      = 1'b0;
        mem_write     = 1'b0;
        mem_address   = '0;
        store_data    = '0;
        lfsr_state    = 32'h0000_261a;
        waited        = 0;
        @(negedge clk);
        while (rst) begin
            if (waited == RESET_TIMEOUT) begin
                abort_run("TIMEOUT: reset was never released");
            end
            else begin
                waited++;
                @(negedge clk);
            end
        end

        run_step(32'h0000_0000, 1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0);
        run_step(32'h0000_03fc, 1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0);
        run_step(32'h0000_0004, 1'b0, '0, 1'b1, 1'b0, 32'h0000_0100, '0, 1'b0);
        run_step(32'h0000_0008, 1'b0, '0, 1'b0, 1'b1, 32'h0000_0080, 32'hdead_beef, 1'b0);
        run_step(32'h0000_000c, 1'b0, '0, 1'b1, 1'b0, 32'h0000_0080, '0, 1'b0);
        run_step(32'h0000_0400, 1'b0, '0, 1'b0, 1'b0, '0, '0, 1'b0);
        run_step(32'h0000_0010, 1'b1, 32'h0000_02c0, 1'b0, 1'b0, '0, '0, 1'b0);
        run_step(32'h0000_0024, 1'b0, '0, 1'b0, 1'b1, 32'h0000_0024, 32'h1234_5678, 1'b0);
        run_step(32'h0000_0028, 1'b0, '0, 1'b1, 1'b0, 32'h8000_0000, '0, 1'b0);

        repeat (NUM_RANDOM) begin
            choice   = random_bits(2);
            r_pc     = random_bits(MEM_IDX_W) << ADDR_LSB;
            r_taken  = (random_bits(2) == '0);
            r_target = random_bits(MEM_IDX_W) << ADDR_LSB;
            r_addr   = random_bits(4) << ADDR_LSB;          // few words so loads meet earlier stores
            r_data   = random_bits(32);
            run_step(r_pc, r_taken, r_target, choice == 32'd1, choice == 32'd2,
                     r_addr, r_data, 1'b1);
        end

        hold = 1'b0;
        if (checked_steps != NUM_STEPS) begin
            abort_run($sformatf("only %0d of %0d steps were checked", checked_steps, NUM_STEPS));
        end
        else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: src.f
rtl/mem_req_pkg.sv
rtl/credit_queue.sv
rtl/mem_request_unit.sv
rtl/mem_bus_unit.sv
rtl/wait_state_mem.sv
rtl/mem_subsys_top.sv
verification/tb_clk_gen.sv
verification/mem_subsys_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
